// ==== usb_bus_pkg.sv ====
// Local bus and APB definitions
package usb_bus_pkg;

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0]  bus_sel_t;
	typedef logic [7:0]  apb_addr_t;
	typedef logic [1:0]  mbox_ofs_t;      // word offset inside the hostif region

	// region is taken from address bits 31:30
	typedef enum logic [1:0] {
		REG_RAM    = 2'd0,
		REG_TIMER  = 2'd1,
		REG_HOSTIF = 2'd2,
		REG_SIE    = 2'd3
	} bus_region_e;

	typedef struct packed {
		logic      re;
		logic      we;
		bus_addr_t addr;
		bus_sel_t  sel;
		bus_data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		bus_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		bus_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	localparam int unsigned RAM_WORDS = 256;
	typedef logic [$clog2(RAM_WORDS)-1:0] ram_idx_t;

	localparam mbox_ofs_t HOSTIF_MBOX_OFS     = 2'd0;
	localparam mbox_ofs_t HOSTIF_HOSTMBOX_OFS = 2'd1;

	localparam apb_addr_t APB_DEVMBOX_ADDR  = 8'h00;
	localparam apb_addr_t APB_HOSTMBOX_ADDR = 8'h04;
	localparam apb_addr_t APB_STATUS_ADDR   = 8'h08;

endpackage

// ==== usb_line_pkg.sv ====
// USB line coding definitions
package usb_line_pkg;

	typedef struct packed {
		logic oe;  // driver enable
		logic dp;
		logic dm;
	} line_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_SYNC_DATA,
		S_EOP_SE0,
		S_EOP_J
	} sie_state_e;

	localparam int unsigned BIT_DIV      = 4;   // clocks per line bit
	localparam int unsigned STUFF_LIMIT  = 6;
	localparam int unsigned EOP_SE0_BITS = 2;
	localparam int unsigned FRAME_BITS   = 16;  // sync byte plus one data byte

	localparam logic [7:0] SYNC_BYTE = 8'h80;

	typedef logic [FRAME_BITS-1:0]                 frame_t;
	typedef logic [$clog2(FRAME_BITS+1)-1:0]       bit_cnt_t;
	typedef logic [$clog2(BIT_DIV)-1:0]            div_cnt_t;
	typedef logic [$clog2(STUFF_LIMIT+1)-1:0]      ones_cnt_t;
	typedef logic [$clog2(EOP_SE0_BITS)-1:0]       eop_cnt_t;

endpackage

// ==== usb_bus_ctrl.sv ====
// Local bus decode and acknowledge
`timescale 1ns/1ps

module usb_bus_ctrl (
	input  logic                   usb_clk,
	input  logic                   usb_rst,
	input  usb_bus_pkg::bus_req_t  bus_i,
	output logic                   done_o,
	output logic [3:0]             region_we_o,
	output logic                   sie_re_o,
	input  usb_bus_pkg::bus_data_t ram_rdata_i,
	input  usb_bus_pkg::bus_data_t timer_rdata_i,
	input  usb_bus_pkg::bus_data_t hostif_rdata_i,
	input  usb_bus_pkg::bus_data_t sie_rdata_i,
	output usb_bus_pkg::bus_data_t rdata_o
);
	import usb_bus_pkg::*;

	bus_region_e region;
	bus_region_e region_q;
	logic        req;
	logic        first;
	logic        done_q;

	assign region = bus_region_e'(bus_i.addr[31:30]);
	assign req    = bus_i.re | bus_i.we;
	assign first  = req & ~done_q;  // request cycle before the ack

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			done_q   <= 1'b0;
			region_q <= REG_RAM;
		end else begin
			done_q <= first;
			if (first)
				region_q <= region;  // hold the region for the data phase
		end
	end

	// strobes only fire in the first cycle so a held request acts once
	always_comb begin
		region_we_o         = '0;
		region_we_o[region] = bus_i.we & ~done_q;
	end

	assign sie_re_o = bus_i.re & ~done_q & (region == REG_SIE);

	always_comb begin
		case (region_q)
			REG_RAM:    rdata_o = ram_rdata_i;
			REG_TIMER:  rdata_o = timer_rdata_i;
			REG_HOSTIF: rdata_o = hostif_rdata_i;
			default:    rdata_o = sie_rdata_i;
		endcase
	end

	assign done_o = done_q;

endmodule

// ==== usb_ram.sv ====
// Program and data RAM
`timescale 1ns/1ps

module usb_ram (
	input  logic                   usb_clk,
	input  usb_bus_pkg::bus_req_t  bus_i,
	input  logic                   we_i,
	output usb_bus_pkg::bus_data_t rdata_o
);
	import usb_bus_pkg::*;

	bus_data_t mem [RAM_WORDS];
	ram_idx_t  idx;
	bus_data_t rdata_q;

	assign idx = ram_idx_t'(bus_i.addr >> 2);  // word address from bits 9:2

	// byte lanes written under the select mask
	always_ff @(posedge usb_clk) begin
		if (we_i) begin
			for (int i = 0; i < 4; i++) begin
				if (bus_i.sel[i])
					mem[idx][i*8 +: 8] <= bus_i.wdata[i*8 +: 8];
			end
		end
	end

	// read data lands in the done cycle
	always_ff @(posedge usb_clk) begin
		rdata_q <= mem[idx];
	end

	assign rdata_o = rdata_q;

endmodule

// ==== usb_timer.sv ====
// Free-running cycle timer
`timescale 1ns/1ps

module usb_timer (
	input  logic                   usb_clk,
	input  logic                   usb_rst,
	input  logic                   we_i,
	output usb_bus_pkg::bus_data_t count_o
);
	import usb_bus_pkg::*;

	bus_data_t count_q;

	always_ff @(posedge usb_clk) begin
		if (usb_rst)
			count_q <= '0;
		else if (we_i)
			count_q <= '0;  // any write restarts the count
		else
			count_q <= count_q + 1'b1;
	end

	assign count_o = count_q;

endmodule

// ==== usb_hostif.sv ====
// Host interface mailboxes
`timescale 1ns/1ps

module usb_hostif (
	input  logic                   usb_clk,
	input  logic                   usb_rst,
	input  usb_bus_pkg::apb_req_t  apb_i,
	output usb_bus_pkg::apb_rsp_t  apb_o,
	input  usb_bus_pkg::bus_req_t  bus_i,
	input  logic                   we_i,
	input  logic                   region_hit_i,
	output usb_bus_pkg::bus_data_t rdata_o,
	output logic                   irq_o
);
	import usb_bus_pkg::*;

	bus_data_t dev_mbox_q;   // device to host
	bus_data_t host_mbox_q;  // host to device
	logic      pending_q;
	logic      irq_q;

	logic      access;
	logic      addr_ok;
	bus_data_t prdata;
	logic      apb_wr_host;
	logic      apb_rd_dev;
	logic      cpu_wr_dev;

	assign access = apb_i.psel & apb_i.penable;

	always_comb begin
		addr_ok = 1'b1;
		case (apb_i.paddr)
			APB_DEVMBOX_ADDR:  prdata = dev_mbox_q;
			APB_HOSTMBOX_ADDR: prdata = host_mbox_q;
			APB_STATUS_ADDR:   prdata = {30'b0, irq_q, pending_q};
			default: begin
				prdata  = '0;
				addr_ok = 1'b0;
			end
		endcase
	end

	assign apb_wr_host = access & apb_i.pwrite & (apb_i.paddr == APB_HOSTMBOX_ADDR);
	assign apb_rd_dev  = access & ~apb_i.pwrite & (apb_i.paddr == APB_DEVMBOX_ADDR);
	assign cpu_wr_dev  = we_i & (mbox_ofs_t'(bus_i.addr[3:2]) == HOSTIF_MBOX_OFS);

	always_ff @(posedge usb_clk) begin
		if (cpu_wr_dev)
			dev_mbox_q <= bus_i.wdata;
		if (apb_wr_host)
			host_mbox_q <= apb_i.pwdata;
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			pending_q <= 1'b0;
			irq_q     <= 1'b0;
		end else begin
			if (apb_wr_host)
				pending_q <= 1'b1;  // a new host word wins over the read
			else if (region_hit_i)
				pending_q <= 1'b0;
			if (cpu_wr_dev)
				irq_q <= 1'b1;
			else if (apb_rd_dev)
				irq_q <= 1'b0;
		end
	end

	assign apb_o.prdata  = prdata;
	assign apb_o.pready  = access;  // no wait states
	assign apb_o.pslverr = access & ~addr_ok;

	assign rdata_o = host_mbox_q;
	assign irq_o   = irq_q;

endmodule

// ==== usb_sie_tx.sv ====
// Serial interface engine transmitter
`timescale 1ns/1ps

module usb_sie_tx (
	input  logic                   usb_clk,
	input  logic                   usb_rst,
	input  logic                   we_i,
	input  usb_bus_pkg::bus_data_t wdata_i,
	output usb_bus_pkg::bus_data_t status_o,
	output usb_line_pkg::line_t    line_o
);
	import usb_bus_pkg::*;
	import usb_line_pkg::*;

	sie_state_e state_q;
	div_cnt_t   div_q;
	ones_cnt_t  ones_q;
	frame_t     shift_q;
	bit_cnt_t   left_q;
	eop_cnt_t   eop_q;
	logic       level_q;  // NRZI level, 1 is J

	logic       busy;
	logic       accept;
	logic       bit_end;
	logic       step;
	frame_t     src_shift;
	ones_cnt_t  src_ones;
	bit_cnt_t   src_left;
	logic       do_stuff;
	logic       do_data;

	assign busy    = state_q != S_IDLE;
	assign accept  = we_i & ~busy;  // writes while busy are dropped
	assign bit_end = div_q == div_cnt_t'(BIT_DIV - 1);
	assign step    = accept | ((state_q == S_SYNC_DATA) & bit_end);

	// an accepted write emits its first bit straight away
	always_comb begin
		if (accept) begin
			src_shift = {wdata_i[7:0], SYNC_BYTE};
			src_ones  = '0;
			src_left  = bit_cnt_t'(FRAME_BITS);
		end else begin
			src_shift = shift_q;
			src_ones  = ones_q;
			src_left  = left_q;
		end
		do_stuff = src_ones == ones_cnt_t'(STUFF_LIMIT);
		do_data  = ~do_stuff & (src_left != '0);
	end

	always_ff @(posedge usb_clk) begin
		if (step & do_data)
			shift_q <= src_shift >> 1;  // LSB first
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state_q <= S_IDLE;
			div_q   <= '0;
			ones_q  <= '0;
			left_q  <= '0;
			eop_q   <= '0;
			level_q <= 1'b1;
		end else begin
			if (accept || bit_end)
				div_q <= '0;
			else
				div_q <= div_q + 1'b1;

			if (step) begin
				if (do_stuff) begin
					level_q <= ~level_q;  // stuffed zero
					ones_q  <= '0;
				end else if (do_data) begin
					state_q <= S_SYNC_DATA;
					left_q  <= src_left - 1'b1;
					if (src_shift[0]) begin
						ones_q <= src_ones + 1'b1;
					end else begin
						level_q <= ~level_q;
						ones_q  <= '0;
					end
				end else begin
					state_q <= S_EOP_SE0;
					eop_q   <= '0;
				end
			end else if (bit_end) begin
				case (state_q)
					S_EOP_SE0: begin
						if (eop_q == eop_cnt_t'(EOP_SE0_BITS - 1)) begin
							state_q <= S_EOP_J;
							level_q <= 1'b1;  // back to idle level
						end else begin
							eop_q <= eop_q + 1'b1;
						end
					end
					S_EOP_J: state_q <= S_IDLE;
					default: ;
				endcase
			end
		end
	end

	assign status_o  = bus_data_t'(busy);
	assign line_o.oe = busy;
	assign line_o.dp = (state_q == S_EOP_SE0) ? 1'b0 : level_q;
	assign line_o.dm = (state_q == S_EOP_SE0) ? 1'b0 : ~level_q;

endmodule

// ==== usb_ctrl_top.sv ====
// USB host controller top level
`timescale 1ns/1ps

module usb_ctrl_top (
	input  logic                   usb_clk,
	input  logic                   usb_rst,
	input  usb_bus_pkg::bus_req_t  bus_i,
	output logic                   done_o,
	output usb_bus_pkg::bus_data_t rdata_o,
	input  usb_bus_pkg::apb_req_t  apb_i,
	output usb_bus_pkg::apb_rsp_t  apb_o,
	output logic                   irq_o,
	output usb_line_pkg::line_t    line_o
);
	import usb_bus_pkg::*;

	logic [3:0] region_we;
	logic       sie_re;
	logic       hostif_re;
	logic       hostif_hit_q;
	logic       sie_hit_q;
	bus_data_t  ram_rdata;
	bus_data_t  timer_rdata;
	bus_data_t  hostif_rdata;
	bus_data_t  sie_status;
	bus_data_t  sie_rdata;

	// processor read of the host mailbox in its request cycle
	assign hostif_re = bus_i.re & ~done_o
		& (bus_region_e'(bus_i.addr[31:30]) == REG_HOSTIF)
		& (mbox_ofs_t'(bus_i.addr[3:2]) == HOSTIF_HOSTMBOX_OFS);

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			hostif_hit_q <= 1'b0;
			sie_hit_q    <= 1'b0;
		end else begin
			hostif_hit_q <= hostif_re;
			sie_hit_q    <= sie_re;
		end
	end

	assign sie_rdata = sie_hit_q ? sie_status : '0;  // status only during an SIE read

	usb_bus_ctrl i_bus_ctrl (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.bus_i          (bus_i),
		.done_o         (done_o),
		.region_we_o    (region_we),
		.sie_re_o       (sie_re),
		.ram_rdata_i    (ram_rdata),
		.timer_rdata_i  (timer_rdata),
		.hostif_rdata_i (hostif_rdata),
		.sie_rdata_i    (sie_rdata),
		.rdata_o        (rdata_o)
	);

	usb_ram i_ram (
		.usb_clk (usb_clk),
		.bus_i   (bus_i),
		.we_i    (region_we[REG_RAM]),
		.rdata_o (ram_rdata)
	);

	usb_timer i_timer (
		.usb_clk (usb_clk),
		.usb_rst (usb_rst),
		.we_i    (region_we[REG_TIMER]),
		.count_o (timer_rdata)
	);

	usb_hostif i_hostif (
		.usb_clk      (usb_clk),
		.usb_rst      (usb_rst),
		.apb_i        (apb_i),
		.apb_o        (apb_o),
		.bus_i        (bus_i),
		.we_i         (region_we[REG_HOSTIF]),
		.region_hit_i (hostif_hit_q),
		.rdata_o      (hostif_rdata),
		.irq_o        (irq_o)
	);

	usb_sie_tx i_sie_tx (
		.usb_clk  (usb_clk),
		.usb_rst  (usb_rst),
		.we_i     (region_we[REG_SIE]),
		.wdata_i  (bus_i.wdata),
		.status_o (sie_status),
		.line_o   (line_o)
	);

endmodule

// ==== usb_props.sv ====
// Local bus and APB protocol checks
`timescale 1ns/1ps

module usb_props (
	input logic                  usb_clk,
	input logic                  usb_rst,
	input usb_bus_pkg::bus_req_t bus_i,
	input logic                  done_i,
	input usb_bus_pkg::apb_req_t apb_i
);
	logic req;

	assign req = bus_i.re | bus_i.we;

	done_pulse: assert property (@(posedge usb_clk) disable iff (usb_rst)
		done_i |=> !done_i)
		else $error("mem_done high for more than one cycle");

	req_held: assert property (@(posedge usb_clk) disable iff (usb_rst)
		req && !done_i |=> $stable(bus_i))
		else $error("local bus request changed before mem_done");

	penable_next: assert property (@(posedge usb_clk) disable iff (usb_rst)
		apb_i.psel && !apb_i.penable |=> apb_i.psel && apb_i.penable)
		else $error("penable did not follow the setup cycle");

	penable_sel: assert property (@(posedge usb_clk) disable iff (usb_rst)
		apb_i.penable |-> apb_i.psel)
		else $error("penable high without psel");

endmodule

bind usb_ctrl_top usb_props i_props (
	.usb_clk (usb_clk),
	.usb_rst (usb_rst),
	.bus_i   (bus_i),
	.done_i  (done_o),
	.apb_i   (apb_i)
);

// ==== usb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module usb_clk_gen (
	output logic usb_clk_o,
	output logic usb_rst_o
);
	initial begin
		usb_clk_o = 1'b0;
		forever #5 usb_clk_o = ~usb_clk_o;  // 10 ns period
	end

	initial begin
		usb_rst_o = 1'b1;
		repeat (4) @(posedge usb_clk_o);
		usb_rst_o <= 1'b0;
	end

endmodule

// ==== usb_tb.sv ====
// USB controller testbench
`timescale 1ns/1ps

module usb_tb;
	import usb_bus_pkg::*;
	import usb_line_pkg::*;

	localparam int unsigned TIMEOUT = 200;  // cycles allowed per wait

	logic        usb_clk;
	logic        usb_rst;
	bus_req_t    bus;
	apb_req_t    apb;
	apb_rsp_t    apb_rsp;
	logic        done;
	bus_data_t   rdata;
	logic        irq;
	line_t       line;
	int unsigned errors = 0;
	int unsigned checks = 0;
	int unsigned cycle = 0;

	usb_clk_gen i_clk_gen (
		.usb_clk_o (usb_clk),
		.usb_rst_o (usb_rst)
	);

	usb_ctrl_top i_dut (
		.usb_clk (usb_clk),
		.usb_rst (usb_rst),
		.bus_i   (bus),
		.done_o  (done),
		.rdata_o (rdata),
		.apb_i   (apb),
		.apb_o   (apb_rsp),
		.irq_o   (irq),
		.line_o  (line)
	);

	always @(posedge usb_clk) cycle <= cycle + 1;  // reference count for the timer

	task automatic compare(input string name, input bus_data_t got, input bus_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Error at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
	endtask

	function automatic bus_addr_t region_addr(input bus_region_e r, input int unsigned word);
		return {r, 30'(word << 2)};
	endfunction

	// stuffed zeros expected for a frame sent LSB first
	function automatic int unsigned count_stuff(input frame_t frame);
		int unsigned ones;
		int unsigned n;
		ones = 0;
		n = 0;
		for (int i = 0; i < FRAME_BITS; i++) begin
			ones = frame[i] ? ones + 1 : 0;
			if (ones == STUFF_LIMIT) begin
				n++;
				ones = 0;
			end
		end
		return n;
	endfunction

	task automatic wait_done(output int unsigned at);
		int unsigned n;
		n = 0;
		do begin
			@(negedge usb_clk);
			n++;
		end while (!done && n < TIMEOUT);
		if (!done)
			report_timeout("mem_done");
		at = cycle;
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_sel_t sel, input bus_data_t data);
		int unsigned at;
		@(posedge usb_clk);
		bus <= '{re: 1'b0, we: 1'b1, addr: addr, sel: sel, wdata: data};
		wait_done(at);
		@(posedge usb_clk);
		bus <= '0;  // dropped in the done cycle
	endtask

	task automatic bus_read(input bus_addr_t addr, output bus_data_t data, output int unsigned at);
		@(posedge usb_clk);
		bus <= '{re: 1'b1, we: 1'b0, addr: addr, sel: 4'hF, wdata: '0};
		wait_done(at);
		data = rdata;  // valid while done is high
		@(posedge usb_clk);
		bus <= '0;
	endtask

	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input bus_data_t wdata,
			output bus_data_t data, output logic err);
		int unsigned n;
		@(posedge usb_clk);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge usb_clk);
		apb.penable <= 1'b1;
		n = 0;
		do begin
			@(negedge usb_clk);
			n++;
		end while (!apb_rsp.pready && n < TIMEOUT);
		if (!apb_rsp.pready)
			report_timeout("pready");
		data = apb_rsp.prdata;
		err  = apb_rsp.pslverr;
		@(posedge usb_clk);
		apb <= '0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input bus_data_t data, output logic err);
		bus_data_t rd_ignored;
		apb_xfer(1'b1, addr, data, rd_ignored, err);
	endtask

	task automatic apb_read(input apb_addr_t addr, output bus_data_t data, output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	// samples mid-bit from the oe rise, undoes NRZI and stuffing, then checks the EOP
	task automatic capture_frame(output frame_t bits, output int unsigned stuffed);
		logic        prev;
		logic        bitv;
		int unsigned ones;
		int unsigned nbits;
		int unsigned n;
		int unsigned se0;
		line_t       s;
		bits = '0;
		stuffed = 0;
		n = 0;
		while (!line.oe && n < TIMEOUT) begin
			@(negedge usb_clk);
			n++;
		end
		if (!line.oe) begin
			report_timeout("line output enable");
			return;
		end
		repeat (BIT_DIV / 2) @(negedge usb_clk);
		prev = 1'b1;  // idle J
		ones = 0;
		nbits = 0;
		n = 0;
		s = line;
		while ((s.dp || s.dm) && n < 2 * FRAME_BITS) begin
			compare("line.oe", s.oe, 1'b1);
			compare("line.dm", s.dm, !s.dp);
			if (ones == STUFF_LIMIT) begin
				if (s.dp != prev) begin
					stuffed++;
				end else begin
					errors++;
					$display("Error at %0t ns: no stuffed zero after six ones", $time);
				end
				ones = 0;
			end else begin
				bitv = s.dp == prev;  // a held level is a one under NRZI
				if (nbits < FRAME_BITS)
					bits[nbits] = bitv;
				nbits++;
				ones = bitv ? ones + 1 : 0;
			end
			prev = s.dp;
			repeat (BIT_DIV) @(negedge usb_clk);
			s = line;
			n++;
		end
		compare("frame bit count", nbits, FRAME_BITS);
		se0 = 0;
		while (s.oe && !s.dp && !s.dm && se0 < 8) begin
			se0++;
			repeat (BIT_DIV) @(negedge usb_clk);
			s = line;
		end
		compare("eop se0 bits", se0, EOP_SE0_BITS);
		compare("eop J bit", s, 3'b110);  // oe, dp, dm
		repeat (BIT_DIV) @(negedge usb_clk);
		compare("line.oe after eop", line.oe, 1'b0);
	endtask

	task automatic reset_test();
		int unsigned n;
		int unsigned at;
		bus_data_t   st;
		n = 0;
		do begin
			@(negedge usb_clk);
			n++;
		end while (usb_rst !== 1'b0 && n < TIMEOUT);
		if (usb_rst !== 1'b0)
			report_timeout("reset release");
		compare("mem_done", done, 1'b0);
		compare("irq", irq, 1'b0);
		compare("pready", apb_rsp.pready, 1'b0);
		compare("line", line, 3'b010);  // oe low, line at J
		bus_read(region_addr(REG_SIE, 0), st, at);
		compare("sie busy after reset", st, 32'h0);
	endtask

	task automatic ram_test();
		bus_data_t   model [16];
		bus_data_t   data;
		bus_data_t   got;
		bus_sel_t    sel;
		int unsigned base;
		int unsigned at;
		base = $urandom_range(RAM_WORDS - 1);
		for (int i = 0; i < 16; i++) begin
			model[i] = $urandom;
			bus_write(region_addr(REG_RAM, (base + i) % RAM_WORDS), 4'hF, model[i]);
		end
		for (int i = 0; i < 16; i++) begin
			data = $urandom;
			sel  = bus_sel_t'($urandom);
			bus_write(region_addr(REG_RAM, (base + i) % RAM_WORDS), sel, data);
			for (int b = 0; b < 4; b++) begin
				if (sel[b])
					model[i][b*8 +: 8] = data[b*8 +: 8];
			end
		end
		for (int i = 0; i < 16; i++) begin
			bus_read(region_addr(REG_RAM, (base + i) % RAM_WORDS), got, at);
			compare("ram word", got, model[i]);
		end
	endtask

	task automatic timer_test();
		bus_data_t   t0;
		bus_data_t   t1;
		int unsigned at0;
		int unsigned at1;
		bus_write(region_addr(REG_TIMER, 0), 4'hF, 32'hFFFF_FFFF);
		bus_read(region_addr(REG_TIMER, 0), t0, at0);
		if (t0 > 8) begin  // a handful of cycles since the clearing write
			errors++;
			$display("Error at %0t ns: timer was not cleared by the write", $time);
		end
		repeat ($urandom_range(20)) @(posedge usb_clk);
		bus_read(region_addr(REG_TIMER, 0), t1, at1);
		compare("timer delta", t1 - t0, at1 - at0);
	endtask

	task automatic mailbox_test();
		bus_data_t   word;
		bus_data_t   hword;
		bus_data_t   got;
		logic        err;
		int unsigned at;
		word  = $urandom;
		hword = $urandom;
		compare("irq before write", irq, 1'b0);
		bus_write(region_addr(REG_HOSTIF, HOSTIF_MBOX_OFS), 4'hF, word);
		@(negedge usb_clk);
		compare("irq after write", irq, 1'b1);
		apb_read(APB_STATUS_ADDR, got, err);
		compare("status with irq", got, 32'h2);
		apb_read(APB_DEVMBOX_ADDR, got, err);
		compare("apb device mailbox", got, word);
		compare("apb device mailbox pslverr", err, 1'b0);
		@(negedge usb_clk);
		compare("irq after apb read", irq, 1'b0);
		apb_write(APB_HOSTMBOX_ADDR, hword, err);
		compare("apb host write pslverr", err, 1'b0);
		apb_read(APB_STATUS_ADDR, got, err);
		compare("status with pending", got, 32'h1);
		bus_read(region_addr(REG_HOSTIF, HOSTIF_HOSTMBOX_OFS), got, at);
		compare("cpu host mailbox", got, hword);
		apb_read(APB_STATUS_ADDR, got, err);
		compare("status after cpu read", got, 32'h0);
		apb_read(8'h0C, got, err);
		compare("unmapped read pslverr", err, 1'b1);
		apb_write(8'h10, $urandom, err);
		compare("unmapped write pslverr", err, 1'b1);
		apb_read(APB_HOSTMBOX_ADDR, got, err);
		compare("host mailbox kept", got, hword);
		apb_read(APB_STATUS_ADDR, got, err);
		compare("status kept", got, 32'h0);
	endtask

	task automatic sie_frame_test(input logic [7:0] data);
		frame_t      bits;
		int unsigned stuffed;
		fork
			capture_frame(bits, stuffed);
			bus_write(region_addr(REG_SIE, 0), 4'h1, {24'h0, data});
		join
		compare("frame bits", bits, {data, SYNC_BYTE});
		compare("stuffed bits", stuffed, count_stuff({data, SYNC_BYTE}));
	endtask

	task automatic sie_busy_test();
		frame_t      bits;
		int unsigned stuffed;
		int unsigned at;
		int unsigned n;
		bus_data_t   st;
		fork
			capture_frame(bits, stuffed);
			begin
				bus_write(region_addr(REG_SIE, 0), 4'h1, 32'hFF);
				bus_read(region_addr(REG_SIE, 0), st, at);
				compare("sie busy", st, 32'h1);
				bus_write(region_addr(REG_SIE, 0), 4'h1, 32'h55);  // dropped
			end
		join
		compare("busy frame bits", bits, {8'hFF, SYNC_BYTE});
		compare("busy frame stuffed bits", stuffed, count_stuff({8'hFF, SYNC_BYTE}));
		bus_read(region_addr(REG_SIE, 0), st, at);
		compare("sie idle", st, 32'h0);
		n = 0;
		repeat (8 * BIT_DIV) begin
			@(negedge usb_clk);
			if (line.oe)
				n++;
		end
		compare("oe cycles after dropped write", n, 0);
	endtask

	initial begin
		bus = '0;
		apb = '0;
		void'($urandom(32'h8e4f_5185));
		reset_test();
		ram_test();
		timer_test();
		mailbox_test();
		for (int i = 0; i < 4; i++)
			sie_frame_test(8'($urandom));
		sie_busy_test();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== sim.f ====
usb_bus_pkg.sv
usb_line_pkg.sv
usb_bus_ctrl.sv
usb_ram.sv
usb_timer.sv
usb_hostif.sv
usb_sie_tx.sv
usb_ctrl_top.sv
usb_props.sv
usb_clk_gen.sv
usb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module usb_tb --Mdir obj_dir -o usb_sim \
	-f sim.f

./obj_dir/usb_sim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
